// File: Makefile
TOP := tb_requantize

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf obj_dir

// File: compile.f
src/quant_pkg.sv
src/array_pkg.sv
src/acc_if.sv
src/output_buffer.sv
src/scale_table.sv
src/requant_unit.sv
src/requantize_controller.sv
test/requant_properties.sv
test/tb_requantize.sv

// File: src/acc_if.sv
`timescale 1ns/10ps
`default_nettype none

// One buffered accumulator result per cycle, no stall path
interface acc_if;

  logic              valid; // Entry is consumed in the same cycle
  quant_pkg::acc_t   acc;
  array_pkg::coord_t row;
  array_pkg::coord_t col;

  modport src (
    output valid
    ,output acc
    ,output row
    ,output col
  );

  modport dst (
    input  valid
    ,input acc
    ,input row
    ,input col
  );

endinterface

`default_nettype wire

// File: src/array_pkg.sv
`default_nettype none

package array_pkg;

  // Array geometry
  localparam int SA_N     = 2; // Output channels
  localparam int WR_PORTS = 4; // Write ports per channel
  localparam int COORD_W  = 6;

  typedef logic [COORD_W-1:0] coord_t;

  // Result buffer sizing
  localparam int BUF_DEPTH = 8;
  localparam int BUF_PTR_W = $clog2(BUF_DEPTH);

  typedef logic [BUF_PTR_W-1:0]            buf_ptr_t;
  typedef logic [$clog2(BUF_DEPTH+1)-1:0]  buf_cnt_t; // Holds 0..BUF_DEPTH

  // Layers
  localparam int NUM_LAYERS = 8;

  typedef logic [$clog2(NUM_LAYERS)-1:0] layer_t;

  localparam layer_t SPECIAL_LAYER_IDX = 3'd7;

  // Wishbone register map, word addresses
  // 2L is the multiplier of layer L, 2L+1 its shift
  localparam int WB_ADR_W = 5;
  localparam int WB_DAT_W = 32;

  localparam logic [WB_ADR_W-1:0] REG_LAYER = 5'd16; // Current layer index

endpackage

`default_nettype wire

// File: src/output_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module output_buffer (
  input  logic                clk
  ,input logic                rst_n

  // Parallel write ports of one channel
  ,input logic                in_valid [array_pkg::WR_PORTS]
  ,input quant_pkg::acc_t     in_acc   [array_pkg::WR_PORTS]
  ,input array_pkg::coord_t   in_row   [array_pkg::WR_PORTS]
  ,input array_pkg::coord_t   in_col   [array_pkg::WR_PORTS]

  // Head entry, popped whenever valid
  ,acc_if.src                 head
  ,output logic               empty
);

  // Entry storage
  quant_pkg::acc_t     mem_acc [array_pkg::BUF_DEPTH];
  array_pkg::coord_t   mem_row [array_pkg::BUF_DEPTH];
  array_pkg::coord_t   mem_col [array_pkg::BUF_DEPTH];

  array_pkg::buf_ptr_t rd_ptr;
  array_pkg::buf_ptr_t wr_ptr;
  array_pkg::buf_cnt_t count;

  array_pkg::buf_ptr_t wr_slot [array_pkg::WR_PORTS];
  logic                wr_en   [array_pkg::WR_PORTS];
  array_pkg::buf_cnt_t n_acc;   // Writes accepted this cycle
  logic                pop;

  assign pop = (count != '0);

  // Pack the valid ports in port order behind the tail
  // A slot freed by this cycle's pop is not reused until the next cycle
  always_comb begin
    n_acc = '0;
    for (int p = 0; p < array_pkg::WR_PORTS; p++) begin
      wr_slot[p] = wr_ptr + array_pkg::buf_ptr_t'(n_acc);
      wr_en[p]   = in_valid[p] && (int'(count) + int'(n_acc) < array_pkg::BUF_DEPTH);
      if (wr_en[p]) begin
        n_acc = n_acc + 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      rd_ptr <= rd_ptr + array_pkg::buf_ptr_t'(pop);
      wr_ptr <= wr_ptr + array_pkg::buf_ptr_t'(n_acc);
      count  <= count + n_acc - array_pkg::buf_cnt_t'(pop);
    end
  end

  always_ff @(posedge clk) begin
    for (int p = 0; p < array_pkg::WR_PORTS; p++) begin
      if (wr_en[p]) begin
        mem_acc[wr_slot[p]] <= in_acc[p];
        mem_row[wr_slot[p]] <= in_row[p];
        mem_col[wr_slot[p]] <= in_col[p];
      end
    end
  end

  assign head.valid = pop;
  assign head.acc   = mem_acc[rd_ptr];
  assign head.row   = mem_row[rd_ptr];
  assign head.col   = mem_col[rd_ptr];
  assign empty      = !pop;

endmodule

`default_nettype wire

// File: src/quant_pkg.sv
`default_nettype none

package quant_pkg;

  // Arithmetic types of the requantize path
  typedef logic signed [31:0] acc_t;   // Accumulator result from the array
  typedef logic signed [7:0]  qdata_t; // Requantized activation
  typedef logic signed [31:0] mult_t;  // Per-layer fixed point multiplier
  typedef logic        [5:0]  shift_t; // Rounding right shift amount

  // Full product of acc_t and mult_t
  typedef logic signed [63:0] prod_t;

  // Clamp bounds of the int8 output
  localparam int QMIN = -128;
  localparam int QMAX = 127;

  // Zero point applied on the special layer, all others use zero
  localparam int ZP_SPECIAL = -128;

endpackage

`default_nettype wire

// File: src/requant_unit.sv
`timescale 1ns/10ps
`default_nettype none

module requant_unit (
  input  logic               clk
  ,input logic               rst_n

  ,acc_if.dst                entry

  // Scale of the current layer, sampled on accept
  ,input quant_pkg::mult_t   mult
  ,input quant_pkg::shift_t  shift
  ,input logic               special

  ,output logic              out_valid
  ,output array_pkg::coord_t out_row
  ,output array_pkg::coord_t out_col
  ,output quant_pkg::qdata_t out_data
  ,output logic              busy
);

  // Stage 1 holds the full product
  logic              s1_valid;
  quant_pkg::prod_t  s1_prod;
  quant_pkg::shift_t s1_shift;
  logic              s1_special;
  array_pkg::coord_t s1_row;
  array_pkg::coord_t s1_col;

  quant_pkg::prod_t  rnd;
  quant_pkg::prod_t  shifted;
  quant_pkg::prod_t  with_zp;
  quant_pkg::qdata_t clamped;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid  <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      s1_valid  <= entry.valid;
      out_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (entry.valid) begin
      s1_prod    <= quant_pkg::prod_t'(entry.acc) * quant_pkg::prod_t'(mult);
      s1_shift   <= shift;
      s1_special <= special;
      s1_row     <= entry.row;
      s1_col     <= entry.col;
    end
  end

  // Round half up, then arithmetic shift
  always_comb begin
    rnd = '0;
    if (s1_shift != '0) begin
      rnd = quant_pkg::prod_t'(1) <<< (s1_shift - 1'b1);
    end
    shifted = (s1_prod + rnd) >>> s1_shift;
    with_zp = shifted + (s1_special ? quant_pkg::prod_t'(quant_pkg::ZP_SPECIAL) : '0);
    if (with_zp > quant_pkg::prod_t'(quant_pkg::QMAX)) begin
      clamped = quant_pkg::qdata_t'(quant_pkg::QMAX);
    end else if (with_zp < quant_pkg::prod_t'(quant_pkg::QMIN)) begin
      clamped = quant_pkg::qdata_t'(quant_pkg::QMIN);
    end else begin
      clamped = quant_pkg::qdata_t'(with_zp);
    end
  end

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      out_data <= clamped;
      out_row  <= s1_row;
      out_col  <= s1_col;
    end
  end

  assign busy = s1_valid || out_valid;

endmodule

`default_nettype wire

// File: src/requantize_controller.sv
`timescale 1ns/10ps
`default_nettype none

module requantize_controller (
  input  logic                              clk
  ,input logic                              rst_n

  // Result writes, channel c owns ports 4c..4c+3
  ,input logic              in_valid [array_pkg::SA_N*array_pkg::WR_PORTS]
  ,input quant_pkg::acc_t   in_acc   [array_pkg::SA_N*array_pkg::WR_PORTS]
  ,input array_pkg::coord_t in_row   [array_pkg::SA_N*array_pkg::WR_PORTS]
  ,input array_pkg::coord_t in_col   [array_pkg::SA_N*array_pkg::WR_PORTS]

  // Scale table access
  ,input  logic                             wb_cyc
  ,input  logic                             wb_stb
  ,input  logic                             wb_we
  ,input  logic [array_pkg::WB_ADR_W-1:0]   wb_adr
  ,input  logic [array_pkg::WB_DAT_W-1:0]   wb_dat_w
  ,output logic [array_pkg::WB_DAT_W-1:0]   wb_dat_r
  ,output logic                             wb_ack

  // Requantized outputs
  ,output logic              idle
  ,output logic              out_valid [array_pkg::SA_N]
  ,output array_pkg::coord_t out_row   [array_pkg::SA_N]
  ,output array_pkg::coord_t out_col   [array_pkg::SA_N]
  ,output quant_pkg::qdata_t out_data  [array_pkg::SA_N]
);

  // Per-channel view of the flat write ports
  logic              buf_in_valid [array_pkg::SA_N][array_pkg::WR_PORTS];
  quant_pkg::acc_t   buf_in_acc   [array_pkg::SA_N][array_pkg::WR_PORTS];
  array_pkg::coord_t buf_in_row   [array_pkg::SA_N][array_pkg::WR_PORTS];
  array_pkg::coord_t buf_in_col   [array_pkg::SA_N][array_pkg::WR_PORTS];

  logic              buf_empty [array_pkg::SA_N];
  logic              unit_busy [array_pkg::SA_N];

  quant_pkg::mult_t  layer_mult;
  quant_pkg::shift_t layer_shift;
  logic              layer_special;

  always_comb begin
    for (int ch = 0; ch < array_pkg::SA_N; ch++) begin
      for (int p = 0; p < array_pkg::WR_PORTS; p++) begin
        buf_in_valid[ch][p] = in_valid[ch*array_pkg::WR_PORTS + p];
        buf_in_acc[ch][p]   = in_acc[ch*array_pkg::WR_PORTS + p];
        buf_in_row[ch][p]   = in_row[ch*array_pkg::WR_PORTS + p];
        buf_in_col[ch][p]   = in_col[ch*array_pkg::WR_PORTS + p];
      end
    end
  end

  // One table shared by both channels
  scale_table u_scale_table (
    .clk       (clk)
    ,.rst_n    (rst_n)
    ,.wb_cyc   (wb_cyc)
    ,.wb_stb   (wb_stb)
    ,.wb_we    (wb_we)
    ,.wb_adr   (wb_adr)
    ,.wb_dat_w (wb_dat_w)
    ,.wb_dat_r (wb_dat_r)
    ,.wb_ack   (wb_ack)
    ,.mult     (layer_mult)
    ,.shift    (layer_shift)
    ,.special  (layer_special)
  );

  for (genvar ch = 0; ch < array_pkg::SA_N; ch++) begin : g_chan
    acc_if head_if ();

    output_buffer u_buf (
      .clk       (clk)
      ,.rst_n    (rst_n)
      ,.in_valid (buf_in_valid[ch])
      ,.in_acc   (buf_in_acc[ch])
      ,.in_row   (buf_in_row[ch])
      ,.in_col   (buf_in_col[ch])
      ,.head     (head_if.src)
      ,.empty    (buf_empty[ch])
    );

    requant_unit u_unit (
      .clk        (clk)
      ,.rst_n     (rst_n)
      ,.entry     (head_if.dst)
      ,.mult      (layer_mult)
      ,.shift     (layer_shift)
      ,.special   (layer_special)
      ,.out_valid (out_valid[ch])
      ,.out_row   (out_row[ch])
      ,.out_col   (out_col[ch])
      ,.out_data  (out_data[ch])
      ,.busy      (unit_busy[ch])
    );
  end

  // Idle once nothing is buffered or in flight on any channel
  always_comb begin
    idle = 1'b1;
    for (int i = 0; i < array_pkg::SA_N; i++) begin
      idle &= buf_empty[i] && !unit_busy[i];
    end
  end

endmodule

`default_nettype wire

// File: src/scale_table.sv
`timescale 1ns/10ps
`default_nettype none

module scale_table (
  input  logic                              clk
  ,input logic                              rst_n

  // Wishbone classic slave
  ,input  logic                             wb_cyc
  ,input  logic                             wb_stb
  ,input  logic                             wb_we
  ,input  logic [array_pkg::WB_ADR_W-1:0]   wb_adr
  ,input  logic [array_pkg::WB_DAT_W-1:0]   wb_dat_w
  ,output logic [array_pkg::WB_DAT_W-1:0]   wb_dat_r
  ,output logic                             wb_ack

  // Scale of the current layer
  ,output quant_pkg::mult_t                 mult
  ,output quant_pkg::shift_t                shift
  ,output logic                             special
);

  quant_pkg::mult_t  mult_tab  [array_pkg::NUM_LAYERS];
  quant_pkg::shift_t shift_tab [array_pkg::NUM_LAYERS];
  array_pkg::layer_t layer_q;

  array_pkg::layer_t              tab_idx;
  logic                           req;
  logic                           hit_tab;
  logic                           hit_layer;
  logic [array_pkg::WB_DAT_W-1:0] rd_data;

  // New access only when ack is low, so every cycle gets exactly one ack
  assign req       = wb_cyc && wb_stb && !wb_ack;
  assign hit_tab   = int'(wb_adr) < 2 * array_pkg::NUM_LAYERS;
  assign hit_layer = (wb_adr == array_pkg::REG_LAYER);
  assign tab_idx   = array_pkg::layer_t'(wb_adr >> 1); // Layer L sits at 2L and 2L+1

  always_comb begin
    rd_data = '0; // Unmapped reads return zero
    if (hit_tab && wb_adr[0]) begin
      rd_data = {{(array_pkg::WB_DAT_W - $bits(quant_pkg::shift_t)){1'b0}},
                 shift_tab[tab_idx]};
    end else if (hit_tab) begin
      rd_data = mult_tab[tab_idx];
    end else if (hit_layer) begin
      rd_data = {{(array_pkg::WB_DAT_W - $bits(array_pkg::layer_t)){1'b0}}, layer_q};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_ack  <= 1'b0;
      layer_q <= '0;
      for (int i = 0; i < array_pkg::NUM_LAYERS; i++) begin
        mult_tab[i]  <= '0;
        shift_tab[i] <= '0;
      end
    end else begin
      wb_ack <= req;
      if (req && wb_we) begin
        if (hit_tab && wb_adr[0]) begin
          shift_tab[tab_idx] <= quant_pkg::shift_t'(wb_dat_w); // Low 6 bits only
        end else if (hit_tab) begin
          mult_tab[tab_idx] <= quant_pkg::mult_t'(wb_dat_w);
        end else if (hit_layer) begin
          layer_q <= array_pkg::layer_t'(wb_dat_w);
        end
      end
    end
  end

  // Read data is held with the ack
  always_ff @(posedge clk) begin
    if (req) begin
      wb_dat_r <= rd_data;
    end
  end

  assign mult    = mult_tab[layer_q];
  assign shift   = shift_tab[layer_q];
  assign special = (layer_q == array_pkg::SPECIAL_LAYER_IDX);

endmodule

`default_nettype wire

// File: test/requant_properties.sv
`timescale 1ns/10ps
`default_nettype none

module requant_properties (
  input  logic clk
  ,input logic rst_n
  ,input logic in_valid [array_pkg::SA_N*array_pkg::WR_PORTS]
  ,input logic wb_ack
  ,input logic out_valid [array_pkg::SA_N]
);

  int wr_cnt  [array_pkg::SA_N]; // Writes offered this cycle
  int occ     [array_pkg::SA_N]; // Buffer fill seen from the ports
  int pending [array_pkg::SA_N]; // Written but not yet delivered

  always_comb begin
    for (int ch = 0; ch < array_pkg::SA_N; ch++) begin
      wr_cnt[ch] = 0;
      for (int p = 0; p < array_pkg::WR_PORTS; p++) begin
        wr_cnt[ch] += int'(in_valid[ch*array_pkg::WR_PORTS + p]);
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int ch = 0; ch < array_pkg::SA_N; ch++) begin
        occ[ch]     <= 0;
        pending[ch] <= 0;
      end
    end else begin
      for (int ch = 0; ch < array_pkg::SA_N; ch++) begin
        occ[ch]     <= occ[ch] + wr_cnt[ch] - ((occ[ch] != 0) ? 1 : 0);
        pending[ch] <= pending[ch] + wr_cnt[ch] - int'(out_valid[ch]);
      end
    end
  end

  for (genvar ch = 0; ch < array_pkg::SA_N; ch++) begin : g_chan
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
      occ[ch] + wr_cnt[ch] <= array_pkg::BUF_DEPTH)
      else $error("Channel %0d written beyond buffer capacity", ch);

    a_out_after_write: assert property (@(posedge clk) disable iff (!rst_n)
      out_valid[ch] |-> pending[ch] > 0)
      else $error("Channel %0d output without an earlier write", ch);
  end

  // One ack per access
  a_ack_single: assert property (@(posedge clk) disable iff (!rst_n) wb_ack |=> !wb_ack)
    else $error("wb_ack high for two cycles in a row");

endmodule

bind requantize_controller requant_properties u_props (
  .clk       (clk)
  ,.rst_n    (rst_n)
  ,.in_valid (in_valid)
  ,.wb_ack   (wb_ack)
  ,.out_valid(out_valid)
);

`default_nettype wire

// File: test/requant_stim.txt
# W adr data | R adr expected | D portmask, then acc row col per set bit | E ch data row col
# All fields hex, port bit k belongs to channel k/4
W 00 00000001
W 01 00000000
W 02 00000003
W 03 FFFFFFC2
W 06 40000000
W 07 0000001F
W 0E 00000001
W 0F 00000001
W 11 DEADBEEF
R 00 00000001
R 02 00000003
R 03 00000002
R 06 40000000
R 07 0000001F
R 0F 00000001
R 08 00000000
R 11 00000000
R 10 00000000
W 10 00000001
R 10 00000001
# Layer 1 scales by 3/4 with rounding and clamping
D 01 00000002 05 06
E 0 02 05 06
D 10 FFFFFFFE 07 08
E 1 FF 07 08
D 11 000003E8 09 0A FFFFFC18 0B 0C
E 0 7F 09 0A
E 1 80 0B 0C
# Layer 7 halves and adds the -128 zero point
W 10 00000007
D 11 00000064 10 11 00000200 12 13
E 0 B2 10 11
E 1 7F 12 13
# Layer 3 halves without zero point
W 10 00000003
D 11 00000064 16 17 FFFFFFF9 18 19
E 0 32 16 17
E 1 FD 18 19
D FF
00000002 20 01
00000004 21 01
00000006 22 01
00000008 23 01
0000000A 24 02
0000000C 25 02
0000000E 26 02
00000010 27 02
E 0 01 20 01
E 0 02 21 01
E 0 03 22 01
E 0 04 23 01
E 1 05 24 02
E 1 06 25 02
E 1 07 26 02
E 1 08 27 02

// File: test/tb_requantize.sv
`timescale 1ns/10ps
`default_nettype none

module tb_requantize;

  logic clk;
  logic rst_n;

  logic              in_valid [array_pkg::SA_N*array_pkg::WR_PORTS];
  quant_pkg::acc_t   in_acc   [array_pkg::SA_N*array_pkg::WR_PORTS];
  array_pkg::coord_t in_row   [array_pkg::SA_N*array_pkg::WR_PORTS];
  array_pkg::coord_t in_col   [array_pkg::SA_N*array_pkg::WR_PORTS];

  logic                           wb_cyc;
  logic                           wb_stb;
  logic                           wb_we;
  logic [array_pkg::WB_ADR_W-1:0] wb_adr;
  logic [array_pkg::WB_DAT_W-1:0] wb_dat_w;
  logic [array_pkg::WB_DAT_W-1:0] wb_dat_r;
  logic                           wb_ack;

  logic              idle;
  logic              out_valid [array_pkg::SA_N];
  array_pkg::coord_t out_row   [array_pkg::SA_N];
  array_pkg::coord_t out_col   [array_pkg::SA_N];
  quant_pkg::qdata_t out_data  [array_pkg::SA_N];

  // Staged write port values for the next result cycle
  quant_pkg::acc_t   stg_acc [array_pkg::SA_N*array_pkg::WR_PORTS];
  array_pkg::coord_t stg_row [array_pkg::SA_N*array_pkg::WR_PORTS];
  array_pkg::coord_t stg_col [array_pkg::SA_N*array_pkg::WR_PORTS];

  logic [19:0] exp_q [array_pkg::SA_N][$]; // {row, col, data} in arrival order

  quant_pkg::mult_t  sh_mult  [array_pkg::NUM_LAYERS]; // Shadow of the scale table
  quant_pkg::shift_t sh_shift [array_pkg::NUM_LAYERS];
  array_pkg::layer_t cur_layer;
  logic [31:0]       rng_state;

  requantize_controller dut (
    .clk       (clk)
    ,.rst_n    (rst_n)
    ,.in_valid (in_valid)
    ,.in_acc   (in_acc)
    ,.in_row   (in_row)
    ,.in_col   (in_col)
    ,.wb_cyc   (wb_cyc)
    ,.wb_stb   (wb_stb)
    ,.wb_we    (wb_we)
    ,.wb_adr   (wb_adr)
    ,.wb_dat_w (wb_dat_w)
    ,.wb_dat_r (wb_dat_r)
    ,.wb_ack   (wb_ack)
    ,.idle     (idle)
    ,.out_valid(out_valid)
    ,.out_row  (out_row)
    ,.out_col  (out_col)
    ,.out_data (out_data)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic stop_run();
    $display("Finished with errors");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic report_failure(input string what);
    $display("Failure at %0t: %s", $time, what);
    stop_run();
  endtask

  task automatic check_equal(input string name, input logic [31:0] exp, input logic [31:0] got);
    assert (exp == got) else begin
      $display("[ERROR] %0t %s expected 0x%0h got 0x%0h", $time, name, exp, got);
      stop_run();
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic draw_random(output logic [31:0] r);
    rng_state = xorshift32(rng_state);
    r = rng_state;
  endtask

  // Multiply, round half up, shift, zero point, clamp to int8
  function automatic logic [7:0] model_requant(input logic signed [31:0] acc,
                                               input logic signed [31:0] mult,
                                               input logic [5:0] shift, input logic special);
    longint prod;
    longint res;
    prod = longint'(acc) * longint'(mult);
    if (shift != 6'd0) prod = prod + (longint'(1) <<< (shift - 6'd1));
    res = prod >>> shift;
    if (special) res = res + quant_pkg::ZP_SPECIAL;
    if (res > quant_pkg::QMAX) res = quant_pkg::QMAX;
    else if (res < quant_pkg::QMIN) res = quant_pkg::QMIN;
    return res[7:0];
  endfunction

  // Classic cycle, held until ack
  task automatic wb_access(input logic we, input logic [array_pkg::WB_ADR_W-1:0] adr,
                           input logic [31:0] wdata, input logic check, input logic [31:0] exp);
    int waited;
    waited = 0;
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= wdata;
    @(negedge clk);
    while (!wb_ack && waited < 16) begin
      @(negedge clk);
      waited++;
    end
    assert (wb_ack) else report_failure("Wishbone access was never acknowledged");
    if (check) check_equal($sformatf("wb_dat_r@%0h", adr), exp, wb_dat_r);
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  // One cycle of result writes followed by one quiet cycle
  task automatic drive_cycle(input logic [array_pkg::SA_N*array_pkg::WR_PORTS-1:0] mask);
    @(posedge clk);
    for (int k = 0; k < array_pkg::SA_N*array_pkg::WR_PORTS; k++) begin
      in_valid[k] <= mask[k];
      in_acc[k]   <= stg_acc[k];
      in_row[k]   <= stg_row[k];
      in_col[k]   <= stg_col[k];
    end
    @(posedge clk); // Writes are taken on this edge
    for (int k = 0; k < array_pkg::SA_N*array_pkg::WR_PORTS; k++) begin
      in_valid[k] <= 1'b0;
    end
    @(negedge clk);
    assert (!idle || mask == '0) else report_failure("idle stayed high after a result write");
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    @(negedge clk);
    while (!(idle && exp_q[0].size() == 0 && exp_q[1].size() == 0) && waited < 200) begin
      @(negedge clk);
      waited++;
    end
    assert (idle && exp_q[0].size() == 0 && exp_q[1].size() == 0) else begin
      report_failure("Pipeline did not drain or expected outputs never arrived");
    end
  endtask

  task automatic run_stim_file();
    int          fd;
    int          n;
    logic [7:0]  cmd;
    logic [959:0] line_buf;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] d;
    logic [array_pkg::SA_N*array_pkg::WR_PORTS-1:0] mask;
    fd = $fopen("test/requant_stim.txt", "r");
    if (fd == 0) report_failure("Cannot open test/requant_stim.txt");
    while (!$feof(fd)) begin
      n = $fscanf(fd, " %c", cmd);
      if (n != 1) break;
      case (cmd)
        "#": n = $fgets(line_buf, fd);
        "W": begin
          n = $fscanf(fd, "%h %h", a, b);
          wait_drain(); // Scale changes only between batches
          wb_access(1'b1, a[4:0], b, 1'b0, '0);
        end
        "R": begin
          n = $fscanf(fd, "%h %h", a, b);
          wait_drain();
          wb_access(1'b0, a[4:0], '0, 1'b1, b);
        end
        "D": begin
          n = $fscanf(fd, "%h", mask);
          for (int k = 0; k < array_pkg::SA_N*array_pkg::WR_PORTS; k++) begin
            if (mask[k]) n = $fscanf(fd, "%h %h %h", stg_acc[k], stg_row[k], stg_col[k]);
          end
          drive_cycle(mask);
        end
        "E": begin
          n = $fscanf(fd, "%h %h %h %h", a, b, c, d);
          exp_q[int'(a)].push_back({c[5:0], d[5:0], b[7:0]});
        end
        default: report_failure($sformatf("Unknown command '%c' in stim file", cmd));
      endcase
    end
    $fclose(fd);
  endtask

  // Random scales per layer, then 200 results in four layer segments
  task automatic run_random_phase();
    logic [31:0] r;
    int          n;
    int          k;
    int          left;
    int          occ [array_pkg::SA_N];
    logic [array_pkg::SA_N*array_pkg::WR_PORTS-1:0] mask;
    wait_drain();
    for (int l = 0; l < array_pkg::NUM_LAYERS; l++) begin
      draw_random(r);
      sh_mult[l]  = {{16{r[15]}}, r[15:0]};
      sh_shift[l] = 6'(12 + r[31:28]);
      wb_access(1'b1, 5'(2*l), sh_mult[l], 1'b0, '0);
      wb_access(1'b1, 5'(2*l+1), 32'(sh_shift[l]), 1'b0, '0);
      wb_access(1'b0, 5'(2*l), '0, 1'b1, sh_mult[l]);
      wb_access(1'b0, 5'(2*l+1), '0, 1'b1, 32'(sh_shift[l]));
    end
    for (int seg = 0; seg < 4; seg++) begin
      wait_drain();
      draw_random(r);
      cur_layer = r[2:0];
      wb_access(1'b1, array_pkg::REG_LAYER, 32'(cur_layer), 1'b0, '0);
      occ[0] = 0;
      occ[1] = 0;
      left = 50;
      while (left > 0) begin
        mask = '0;
        for (int ch = 0; ch < array_pkg::SA_N; ch++) begin
          draw_random(r);
          n = int'(r % 5);
          if (n > array_pkg::BUF_DEPTH - occ[ch]) n = array_pkg::BUF_DEPTH - occ[ch];
          if (n > left) n = left;
          for (int p = 0; p < n; p++) begin
            k = ch * array_pkg::WR_PORTS + p;
            draw_random(r);
            mask[k]    = 1'b1;
            stg_acc[k] = {{12{r[19]}}, r[19:0]};
            stg_row[k] = r[25:20];
            stg_col[k] = r[31:26];
            exp_q[ch].push_back({stg_row[k], stg_col[k],
                                 model_requant(stg_acc[k], sh_mult[cur_layer], sh_shift[cur_layer],
                                               cur_layer == array_pkg::SPECIAL_LAYER_IDX)});
          end
          left -= n;
          occ[ch] = occ[ch] + n - ((occ[ch] > 0) ? 1 : 0); // Head pops when nonempty
        end
        drive_cycle(mask);
        for (int ch = 0; ch < array_pkg::SA_N; ch++) begin
          if (occ[ch] > 0) occ[ch]--; // Pop in the quiet cycle
        end
      end
    end
  endtask

  // Output monitor, compares against the expected queues
  always @(negedge clk) begin : monitor
    logic [19:0] exp_word;
    if (rst_n) begin
      for (int ch = 0; ch < array_pkg::SA_N; ch++) begin
        if (out_valid[ch]) begin
          assert (exp_q[ch].size() != 0) else begin
            report_failure($sformatf("Channel %0d produced an output that was not expected", ch));
          end
          exp_word = exp_q[ch].pop_front();
          check_equal($sformatf("out_data[%0d]", ch), 32'(exp_word[7:0]), {24'd0, out_data[ch]});
          check_equal($sformatf("out_row[%0d]", ch), 32'(exp_word[19:14]), 32'(out_row[ch]));
          check_equal($sformatf("out_col[%0d]", ch), 32'(exp_word[13:8]), 32'(out_col[ch]));
        end
      end
    end
  end

  initial begin
    rng_state = 32'd95;
    rst_n    <= 1'b0;
    wb_cyc   <= 1'b0;
    wb_stb   <= 1'b0;
    wb_we    <= 1'b0;
    wb_adr   <= '0;
    wb_dat_w <= '0;
    for (int k = 0; k < array_pkg::SA_N*array_pkg::WR_PORTS; k++) begin
      in_valid[k] <= 1'b0;
      in_acc[k]   <= '0;
      in_row[k]   <= '0;
      in_col[k]   <= '0;
      stg_acc[k]  = '0;
      stg_row[k]  = '0;
      stg_col[k]  = '0;
    end
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    assert (idle) else report_failure("idle was low right after reset");
    run_stim_file();
    run_random_phase();
    wait_drain();
    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire
